// File: regex_soc_defines.svh
`ifndef REGEX_SOC_DEFINES_SVH
`define REGEX_SOC_DEFINES_SVH

// software register width
`define REG_WIDTH      32

// shared program/text memory, 2048 words
`define MEM_ADDR_WIDTH 11
`define MEM_DATA_WIDTH 16

`endif

// File: regex_bus_pkg.sv
`include "regex_soc_defines.svh"

package regex_bus_pkg;

    // wishbone classic, host side
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [7:0]              adr; // byte offset
        logic [`REG_WIDTH-1:0]   dat;
        logic [`REG_WIDTH/8-1:0] sel; // byte lanes
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [`REG_WIDTH-1:0] dat;
    } wb_rsp_t;

    // register map
    localparam logic [7:0] REG_DATA_IN   = 8'h00;
    localparam logic [7:0] REG_ADDRESS   = 8'h04;
    localparam logic [7:0] REG_START_PTR = 8'h08;
    localparam logic [7:0] REG_CMD       = 8'h0C;
    localparam logic [7:0] REG_STATUS    = 8'h10; // read-only
    localparam logic [7:0] REG_DATA_OUT  = 8'h14; // read-only

endpackage

// File: regex_core_pkg.sv
`include "regex_soc_defines.svh"

package regex_core_pkg;

    localparam logic [`REG_WIDTH-1:0] CMD_NOP          = 0;
    localparam logic [`REG_WIDTH-1:0] CMD_WRITE        = 1;
    localparam logic [`REG_WIDTH-1:0] CMD_READ         = 2;
    localparam logic [`REG_WIDTH-1:0] CMD_START        = 3;
    localparam logic [`REG_WIDTH-1:0] CMD_RESTART      = 4;
    localparam logic [`REG_WIDTH-1:0] CMD_READ_ELAPSED = 5;
    localparam logic [`REG_WIDTH-1:0] CMD_RESET        = 6;

    localparam int STATUS_WIDTH = 3;

    localparam logic [STATUS_WIDTH-1:0] STATUS_IDLE     = 3'd0;
    localparam logic [STATUS_WIDTH-1:0] STATUS_RUNNING  = 3'd1;
    localparam logic [STATUS_WIDTH-1:0] STATUS_ACCEPTED = 3'd2;
    localparam logic [STATUS_WIDTH-1:0] STATUS_REJECTED = 3'd3;
    localparam logic [STATUS_WIDTH-1:0] STATUS_ERROR    = 3'd4;

    // instruction word is {opcode, operand}
    localparam int          CHAR_WIDTH = 8;
    localparam logic [7:0]  OP_CHAR    = 8'h01;
    localparam logic [7:0]  OP_ANY     = 8'h02;
    localparam logic [7:0]  OP_ACCEPT  = 8'h03;

    typedef struct packed {
        logic [`REG_WIDTH-1:0] data_in;
        logic [`REG_WIDTH-1:0] address;
        logic [`REG_WIDTH-1:0] start_ptr;
        logic [`REG_WIDTH-1:0] cmd;
    } ctrl_regs_t;

    typedef struct packed {
        logic [`REG_WIDTH-1:0] status;
        logic [`REG_WIDTH-1:0] data_out;
    } core_status_t;

    typedef struct packed {
        logic                       valid;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic finish;
        logic accept;
        logic error;
    } match_result_t;

endpackage

// File: regex_reg_block.sv
`timescale 1ns/1ps
`include "regex_soc_defines.svh"

module regex_reg_block (
    input  logic                         clk,
    input  logic                         reset_master,
    input  regex_bus_pkg::wb_req_t       wb_req,
    output regex_bus_pkg::wb_rsp_t       wb_rsp,
    output regex_core_pkg::ctrl_regs_t   regs,
    input  regex_core_pkg::core_status_t status
);
    import regex_bus_pkg::*;

    logic                  ack_q;
    logic                  access;    // new cycle seen this clock
    logic [`REG_WIDTH-1:0] rd_mux;
    logic [`REG_WIDTH-1:0] rd_q;
    logic [`REG_WIDTH-1:0] wr_merged; // current value with enabled lanes replaced

    function automatic logic [`REG_WIDTH-1:0] merge_lanes(
        input logic [`REG_WIDTH-1:0]   old_val,
        input logic [`REG_WIDTH-1:0]   new_val,
        input logic [`REG_WIDTH/8-1:0] lanes
    );
        logic [`REG_WIDTH-1:0] res;
        res = old_val;
        for (int i = 0; i < `REG_WIDTH/8; i++)
        begin
            if (lanes[i])
            begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign access    = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_merged = merge_lanes(rd_mux, wb_req.dat, wb_req.sel);

    always_comb
    begin
        case (wb_req.adr)
            REG_DATA_IN:   rd_mux = regs.data_in;
            REG_ADDRESS:   rd_mux = regs.address;
            REG_START_PTR: rd_mux = regs.start_ptr;
            REG_CMD:       rd_mux = regs.cmd;
            REG_STATUS:    rd_mux = status.status;
            REG_DATA_OUT:  rd_mux = status.data_out;
            default:       rd_mux = '0; // unmapped
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_master)
        begin
            ack_q <= 1'b0;
            regs  <= '0;
        end
        else
        begin
            ack_q <= access; // one-cycle ack
            if (access && wb_req.we)
            begin
                case (wb_req.adr)
                    REG_DATA_IN:   regs.data_in   <= wr_merged;
                    REG_ADDRESS:   regs.address   <= wr_merged;
                    REG_START_PTR: regs.start_ptr <= wr_merged;
                    REG_CMD:       regs.cmd       <= wr_merged;
                    default:       ;              // status, data out ignored
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (access)
        begin
            rd_q <= rd_mux;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_q;

endmodule

// File: regex_cmd_ctrl.sv
`timescale 1ns/1ps
`include "regex_soc_defines.svh"

module regex_cmd_ctrl (
    input  logic                          clk,
    input  logic                          reset_master,
    input  regex_core_pkg::ctrl_regs_t    regs,
    output regex_core_pkg::core_status_t  status,
    output logic                          core_reset,
    output logic [`MEM_ADDR_WIDTH-1:0]    mem_addr,
    output logic                          mem_we,
    output logic [`MEM_DATA_WIDTH-1:0]    mem_wdata,
    output logic                          mem_re,
    input  logic [`MEM_DATA_WIDTH-1:0]    mem_rdata,
    input  regex_core_pkg::mem_req_t      eng_req,
    output logic                          mem_ready,
    output logic                          start_offer,
    output logic [`MEM_ADDR_WIDTH-1:0]    start_ptr,
    input  logic                          start_take,
    input  regex_core_pkg::match_result_t result
);
    import regex_core_pkg::*;

    logic [STATUS_WIDTH-1:0] state_q;
    logic [STATUS_WIDTH-1:0] state_d;
    logic [`REG_WIDTH-1:0]   elapsed_q;
    logic [`REG_WIDTH-1:0]   elapsed_d;
    logic [`REG_WIDTH-1:0]   data_out;
    logic [`REG_WIDTH-1:0]   mem_word;
    logic                    host_access; // register path drives the memory
    logic                    eng_owns;    // engine drives the memory

    // soft reset acts as long as the command is held
    assign core_reset = reset_master || (regs.cmd == CMD_RESET);
    assign mem_word   = {{(`REG_WIDTH-`MEM_DATA_WIDTH){1'b0}}, mem_rdata};

    always_ff @(posedge clk)
    begin
        if (core_reset)
        begin
            state_q   <= STATUS_IDLE;
            elapsed_q <= '0;
        end
        else
        begin
            state_q   <= state_d;
            elapsed_q <= elapsed_d;
        end
    end

    ////////////////////
    // status FSM
    ////////////////////
    always_comb
    begin
        state_d     = state_q;
        elapsed_d   = elapsed_q;
        data_out    = '0;
        host_access = 1'b0;
        eng_owns    = 1'b0;
        start_offer = 1'b0;

        case (state_q)
            STATUS_IDLE, STATUS_ACCEPTED, STATUS_REJECTED, STATUS_ERROR:
            begin
                if (regs.cmd == CMD_WRITE || regs.cmd == CMD_READ)
                begin
                    host_access = 1'b1;
                    data_out    = mem_word;
                end
                else if (regs.cmd == CMD_READ_ELAPSED)
                begin
                    data_out = elapsed_q;
                end
                else if (regs.cmd == CMD_START && state_q == STATUS_IDLE)
                begin
                    start_offer = 1'b1;
                    eng_owns    = 1'b1;
                    if (start_take)
                    begin
                        state_d   = STATUS_RUNNING;
                        elapsed_d = '0; // fresh run
                    end
                end
                else if (regs.cmd == CMD_RESTART && state_q != STATUS_IDLE)
                begin
                    state_d = STATUS_IDLE;
                end
            end
            STATUS_RUNNING:
            begin
                eng_owns = 1'b1;
                if (result.error)
                begin
                    state_d = STATUS_ERROR;
                end
                else if (result.finish)
                begin
                    state_d = result.accept ? STATUS_ACCEPTED : STATUS_REJECTED;
                end
                if (!(&elapsed_q)) // saturate at all ones
                begin
                    elapsed_d = elapsed_q + 1'b1;
                end
            end
            default:
            begin
                state_d = STATUS_IDLE;
            end
        endcase
    end

    ////////////////////
    // memory port mux
    ////////////////////
    assign mem_ready = eng_owns;
    assign mem_addr  = eng_owns ? eng_req.addr : regs.address[`MEM_ADDR_WIDTH-1:0];
    assign mem_re    = eng_owns ? eng_req.valid : host_access;
    assign mem_we    = host_access && (regs.cmd == CMD_WRITE);
    assign mem_wdata = regs.data_in[`MEM_DATA_WIDTH-1:0];
    assign start_ptr = regs.start_ptr[`MEM_ADDR_WIDTH-1:0];

    assign status = '{
        status:   {{(`REG_WIDTH-STATUS_WIDTH){1'b0}}, state_q},
        data_out: data_out
    };

endmodule

// File: regex_mem.sv
`timescale 1ns/1ps
`include "regex_soc_defines.svh"

module regex_mem (
    input  logic                       clk,
    input  logic                       reset_master,
    input  logic [`MEM_ADDR_WIDTH-1:0] addr,
    input  logic                       we,
    input  logic [`MEM_DATA_WIDTH-1:0] wdata,
    input  logic                       re,
    output logic [`MEM_DATA_WIDTH-1:0] rdata
);
    localparam int DEPTH = 1 << `MEM_ADDR_WIDTH;

    logic [`MEM_DATA_WIDTH-1:0] mem_array [DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem_array[addr] <= wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk)
    begin
        if (reset_master)
        begin
            rdata <= '0;
        end
        else if (re)
        begin
            rdata <= mem_array[addr];
        end
    end

endmodule

// File: regex_engine.sv
`timescale 1ns/1ps
`include "regex_soc_defines.svh"

module regex_engine (
    input  logic                          clk,
    input  logic                          reset_master,
    input  logic                          start_offer,
    input  logic [`MEM_ADDR_WIDTH-1:0]    start_ptr,
    output logic                          start_take,
    output regex_core_pkg::mem_req_t      mem_req,
    input  logic                          mem_ready,
    input  logic [`MEM_DATA_WIDTH-1:0]    mem_rdata,
    output regex_core_pkg::match_result_t result
);
    import regex_core_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_INSN_REQ,
        S_INSN_WAIT,
        S_CHAR_REQ,
        S_CHAR_WAIT
    } eng_state_t;

    eng_state_t                 state_q;
    logic [`MEM_ADDR_WIDTH-1:0] pc;
    logic [`MEM_ADDR_WIDTH-1:0] cursor;
    logic [7:0]                 opcode;
    logic [7:0]                 operand;
    logic [7:0]                 fetched_op;
    logic [CHAR_WIDTH-1:0]      text_char;
    logic                       char_hit;

    assign fetched_op = mem_rdata[`MEM_DATA_WIDTH-1 -: 8];
    assign text_char  = mem_rdata[CHAR_WIDTH-1:0]; // one char per word, low byte
    assign char_hit   = (text_char != '0) && (opcode == OP_ANY || text_char == operand);

    assign start_take    = (state_q == S_IDLE) && start_offer;
    assign mem_req.valid = (state_q == S_INSN_REQ) || (state_q == S_CHAR_REQ);
    assign mem_req.addr  = (state_q == S_CHAR_REQ) ? cursor : pc;

    ////////////////////
    // control
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (reset_master)
        begin
            state_q <= S_IDLE;
            result  <= '0;
        end
        else
        begin
            result <= '0; // pulses last one cycle
            case (state_q)
                S_IDLE:
                begin
                    if (start_offer)
                    begin
                        state_q <= S_INSN_REQ;
                    end
                end
                S_INSN_REQ:
                begin
                    if (mem_ready)
                    begin
                        state_q <= S_INSN_WAIT;
                    end
                end
                S_INSN_WAIT:
                begin
                    if (fetched_op == OP_ACCEPT)
                    begin
                        result.finish <= 1'b1;
                        result.accept <= 1'b1;
                        state_q       <= S_IDLE;
                    end
                    else if (fetched_op == OP_CHAR || fetched_op == OP_ANY)
                    begin
                        state_q <= S_CHAR_REQ;
                    end
                    else
                    begin
                        result.error <= 1'b1; // unknown opcode
                        state_q      <= S_IDLE;
                    end
                end
                S_CHAR_REQ:
                begin
                    if (mem_ready)
                    begin
                        state_q <= S_CHAR_WAIT;
                    end
                end
                S_CHAR_WAIT:
                begin
                    if (char_hit)
                    begin
                        state_q <= S_INSN_REQ;
                    end
                    else
                    begin
                        result.finish <= 1'b1; // reject
                        state_q       <= S_IDLE;
                    end
                end
                default:
                begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // pc, cursor and the current instruction
    always_ff @(posedge clk)
    begin
        if (start_take)
        begin
            pc     <= '0;
            cursor <= start_ptr;
        end
        else if (state_q == S_INSN_WAIT)
        begin
            opcode  <= fetched_op;
            operand <= mem_rdata[7:0];
        end
        else if (state_q == S_CHAR_WAIT && char_hit)
        begin
            pc     <= pc + 1'b1;
            cursor <= cursor + 1'b1;
        end
    end

endmodule

// File: regex_soc_top.sv
`timescale 1ns/1ps
`include "regex_soc_defines.svh"

module regex_soc_top (
    input  logic                   clk,
    input  logic                   reset_master,
    input  regex_bus_pkg::wb_req_t wb_req,
    output regex_bus_pkg::wb_rsp_t wb_rsp
);
    import regex_core_pkg::*;

    ctrl_regs_t                 regs;
    core_status_t               status;
    mem_req_t                   eng_req;
    match_result_t              result;
    logic                       core_reset;  // hard or soft reset
    logic [`MEM_ADDR_WIDTH-1:0] mem_addr;
    logic                       mem_we;
    logic [`MEM_DATA_WIDTH-1:0] mem_wdata;
    logic                       mem_re;
    logic [`MEM_DATA_WIDTH-1:0] mem_rdata;
    logic                       mem_ready;
    logic                       start_offer;
    logic [`MEM_ADDR_WIDTH-1:0] start_ptr;
    logic                       start_take;

    // host registers, hard reset only
    regex_reg_block regex_reg_block_inst (
        .clk          (clk),
        .reset_master (reset_master),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .regs         (regs),
        .status       (status)
    );

    regex_cmd_ctrl regex_cmd_ctrl_inst (
        .clk          (clk),
        .reset_master (reset_master),
        .regs         (regs),
        .status       (status),
        .core_reset   (core_reset),
        .mem_addr     (mem_addr),
        .mem_we       (mem_we),
        .mem_wdata    (mem_wdata),
        .mem_re       (mem_re),
        .mem_rdata    (mem_rdata),
        .eng_req      (eng_req),
        .mem_ready    (mem_ready),
        .start_offer  (start_offer),
        .start_ptr    (start_ptr),
        .start_take   (start_take),
        .result       (result)
    );

    regex_mem regex_mem_inst (
        .clk          (clk),
        .reset_master (core_reset),
        .addr         (mem_addr),
        .we           (mem_we),
        .wdata        (mem_wdata),
        .re           (mem_re),
        .rdata        (mem_rdata)
    );

    regex_engine regex_engine_inst (
        .clk          (clk),
        .reset_master (core_reset),
        .start_offer  (start_offer),
        .start_ptr    (start_ptr),
        .start_take   (start_take),
        .mem_req      (eng_req),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .result       (result)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk; // 50% duty
    end

endmodule

// File: regex_soc_tb.sv
`timescale 1ns/1ps
`include "regex_soc_defines.svh"

module regex_soc_tb;
    import regex_bus_pkg::*;
    import regex_core_pkg::*;

    localparam int NUM_ROWS = 8;
    localparam logic [`MEM_ADDR_WIDTH-1:0] READBACK_BASE = 11'h400;

    logic    clk;
    logic    reset_master;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    // match table with program words packed first-word-high
    string                      row_name [NUM_ROWS];
    int                         row_len  [NUM_ROWS];
    logic [63:0]                row_prog [NUM_ROWS];
    string                      row_text [NUM_ROWS];
    logic [`MEM_ADDR_WIDTH-1:0] row_ptr  [NUM_ROWS];
    logic [`REG_WIDTH-1:0]      row_exp  [NUM_ROWS];
    int                         row_count = 0;

    int cycle_count = 0;
    int cycle_limit = 2000; // grows with the table
    int err_count   = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    int seed        = 44;

    tb_clock_gen #(.PERIOD_NS(40)) tb_clock_gen_inst (.clk(clk));

    regex_soc_top regex_soc_top_inst (
        .clk          (clk),
        .reset_master (reset_master),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp)
    );

    ////////////////////
    // table
    ////////////////////
    task automatic add_row(input string name, input int len, input logic [63:0] prog,
                           input string text, input logic [`MEM_ADDR_WIDTH-1:0] ptr,
                           input logic [`REG_WIDTH-1:0] exp);
        row_name[row_count] = name;
        row_len[row_count]  = len;
        row_prog[row_count] = prog;
        row_text[row_count] = text;
        row_ptr[row_count]  = ptr;
        row_exp[row_count]  = exp;
        cycle_limit += 20 * (len + text.len() + 1);
        row_count++;
    endtask

    task automatic build_table();
        add_row("char_seq_acc",  3, 64'h0161_0162_0300_0000, "abc", 11'h100, STATUS_ACCEPTED);
        add_row("char_mismatch", 3, 64'h0161_0163_0300_0000, "abd", 11'h120, STATUS_REJECTED);
        add_row("any_acc",       3, 64'h0200_0163_0300_0000, "xc",  11'h140, STATUS_ACCEPTED);
        add_row("prefix_only",   2, 64'h0161_0300_0000_0000, "abc", 11'h7F0, STATUS_ACCEPTED);
        add_row("short_text",    3, 64'h0161_0200_0300_0000, "a",   11'h160, STATUS_REJECTED);
        add_row("accept_first",  1, 64'h0300_0000_0000_0000, "",    11'h180, STATUS_ACCEPTED);
        add_row("empty_text",    2, 64'h0178_0300_0000_0000, "",    11'h1A0, STATUS_REJECTED);
        add_row("bad_opcode",    2, 64'h0161_0700_0000_0000, "a",   11'h1C0, STATUS_ERROR);
    endtask

    ////////////////////
    // host access
    ////////////////////
    task automatic wb_write(input logic [7:0] adr, input logic [`REG_WIDTH-1:0] dat);
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat, sel: '1};
        @(negedge clk);
        while (!wb_rsp.ack)
            @(negedge clk);
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [`REG_WIDTH-1:0] dat);
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0, sel: '1};
        @(negedge clk);
        while (!wb_rsp.ack)
            @(negedge clk);
        dat    = wb_rsp.dat; // registered with ack
        wb_req = '0;
    endtask

    task automatic send_cmd(input logic [`REG_WIDTH-1:0] cmd);
        wb_write(REG_CMD, cmd);
    endtask

    task automatic mem_write(input logic [`MEM_ADDR_WIDTH-1:0] addr,
                             input logic [`MEM_DATA_WIDTH-1:0] word);
        wb_write(REG_ADDRESS, {{(`REG_WIDTH-`MEM_ADDR_WIDTH){1'b0}}, addr});
        wb_write(REG_DATA_IN, {{(`REG_WIDTH-`MEM_DATA_WIDTH){1'b0}}, word});
        send_cmd(CMD_WRITE);
        send_cmd(CMD_NOP);
    endtask

    task automatic mem_read(input logic [`MEM_ADDR_WIDTH-1:0] addr,
                            output logic [`REG_WIDTH-1:0] dat);
        wb_write(REG_ADDRESS, {{(`REG_WIDTH-`MEM_ADDR_WIDTH){1'b0}}, addr});
        send_cmd(CMD_READ);
        wb_read(REG_DATA_OUT, dat);
        send_cmd(CMD_NOP);
    endtask

    // start and poll until a result state shows up
    task automatic run_match(output logic [`REG_WIDTH-1:0] st);
        send_cmd(CMD_START);
        wb_read(REG_STATUS, st);
        while (st == STATUS_IDLE || st == STATUS_RUNNING)
            wb_read(REG_STATUS, st);
        send_cmd(CMD_NOP);
    endtask

    ////////////////////
    // reporting
    ////////////////////
    task automatic check_equal(input string name, input logic [`REG_WIDTH-1:0] exp,
                               input logic [`REG_WIDTH-1:0] act);
        if (act !== exp)
        begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before)
        begin
            $display("test %s ok", name);
            pass_count++;
        end
        else
        begin
            $display("test %s failed", name);
            fail_count++;
        end
    endtask

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        logic [`REG_WIDTH-1:0]      rd;
        logic [`MEM_DATA_WIDTH-1:0] words [10];
        logic [`MEM_ADDR_WIDTH-1:0] ptr;
        int                         errs;

        reset_master = 1'b1;
        wb_req       = '0;
        build_table();
        repeat (16) @(negedge clk);
        reset_master = 1'b0;

        errs = err_count;
        if (wb_rsp.ack !== 1'b0)
        begin
            $display("ERR after_reset expected ack 0 actual %b", wb_rsp.ack);
            err_count++;
        end
        wb_read(REG_STATUS, rd);
        check_equal("after_reset", STATUS_IDLE, rd);
        wb_read(REG_DATA_OUT, rd);
        check_equal("after_reset", '0, rd);
        finish_test("after_reset", errs);

        // readback words sit at 0x400 and up, clear of program and text
        errs = err_count;
        for (int i = 0; i < 10; i++)
        begin
            words[i] = 16'($random(seed));
            mem_write(READBACK_BASE + 11'(i * 13), words[i]);
        end
        for (int i = 0; i < 10; i++)
        begin
            mem_read(READBACK_BASE + 11'(i * 13), rd);
            check_equal("mem_readback", {16'h0000, words[i]}, rd);
        end
        finish_test("mem_readback", errs);

        for (int r = 0; r < row_count; r++)
        begin
            errs = err_count;
            ptr  = row_ptr[r];
            send_cmd(CMD_RESTART); // back to IDLE from the last result
            send_cmd(CMD_NOP);
            for (int j = 0; j < row_len[r]; j++)
                mem_write(11'(j), row_prog[r][63 - 16*j -: 16]);
            for (int k = 0; k < row_text[r].len(); k++)
                mem_write(ptr + 11'(k), {8'h00, row_text[r][k]});
            mem_write(ptr + 11'(row_text[r].len()), 16'h0000); // terminator
            wb_write(REG_START_PTR, {{(`REG_WIDTH-`MEM_ADDR_WIDTH){1'b0}}, ptr});
            run_match(rd);
            check_equal(row_name[r], row_exp[r], rd);
            finish_test(row_name[r], errs);
        end

        // last row left the core in ERROR
        errs = err_count;
        send_cmd(CMD_START);
        wb_read(REG_STATUS, rd);
        check_equal("error_hold", STATUS_ERROR, rd);
        send_cmd(CMD_NOP);
        send_cmd(CMD_RESTART);
        wb_read(REG_STATUS, rd);
        check_equal("error_hold", STATUS_IDLE, rd);
        send_cmd(CMD_NOP);
        finish_test("error_hold", errs);

        errs = err_count;
        mem_write(11'h000, {OP_ACCEPT, 8'h00});
        run_match(rd);
        check_equal("elapsed_reset", STATUS_ACCEPTED, rd);
        send_cmd(CMD_READ_ELAPSED);
        wb_read(REG_DATA_OUT, rd);
        if (rd === '0 || $isunknown(rd))
        begin
            $display("ERR elapsed_reset expected nonzero actual %h", rd);
            err_count++;
        end
        send_cmd(CMD_NOP);
        send_cmd(CMD_RESET); // soft reset of the core
        send_cmd(CMD_NOP);
        wb_read(REG_STATUS, rd);
        check_equal("elapsed_reset", STATUS_IDLE, rd);
        send_cmd(CMD_READ_ELAPSED);
        wb_read(REG_DATA_OUT, rd);
        check_equal("elapsed_reset", '0, rd);
        send_cmd(CMD_NOP);
        finish_test("elapsed_reset", errs);

        $display("tests ok %0d, tests failed %0d, check errors %0d",
                 pass_count, fail_count, err_count);
        if (fail_count == 0 && err_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// File: regex_soc.f
+incdir+.
regex_bus_pkg.sv
regex_core_pkg.sv
regex_reg_block.sv
regex_cmd_ctrl.sv
regex_mem.sv
regex_engine.sv
regex_soc_top.sv
tb_clock_gen.sv
regex_soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the regex coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module regex_soc_tb -f regex_soc.f -o regex_soc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/regex_soc_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
